// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  ////////////////////
  // Address sizes
  ////////////////////
  localparam int vaddr_width       = 32;
  localparam int paddr_width       = 32;
  localparam int ptag_width        = 20;
  localparam int page_offset_width = 12;

  ////////////////////
  // Cache geometry
  ////////////////////
  localparam int sets        = 64;
  localparam int assoc       = 2;
  localparam int block_width = 128;
  localparam int bank_width  = 64;
  localparam int instr_width = 32;

  // Field widths inside an address
  localparam int sindex_width       = 6;
  localparam int block_offset_width = 4;
  // One bank per way, so a block spans two bank entries
  localparam int bank_offset_width  = 1;

  ////////////////////
  // Vector types
  ////////////////////
  typedef logic [vaddr_width-1:0]   vaddr_t;
  typedef logic [paddr_width-1:0]   paddr_t;
  typedef logic [ptag_width-1:0]    ptag_t;
  typedef logic [sindex_width-1:0]  sindex_t;
  typedef logic [$clog2(assoc)-1:0] way_t;
  typedef logic [assoc-1:0]         way_mask_t;
  typedef logic [block_width-1:0]   block_t;
  typedef logic [bank_width-1:0]    bank_t;
  typedef logic [instr_width-1:0]   instr_t;

  // Miss control
  typedef enum logic [1:0]
  {
    e_ready,
    e_miss,
    e_recover
  } icache_state_e;

endpackage

`default_nettype wire

// ==== icache_tag_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array
  (input  logic                                      clk_i
   , input  logic                                    reset_i
   , input  logic                                    rd_v_i
   , input  icache_pkg::sindex_t                     rd_index_i
   , input  logic                                    wr_v_i
   , input  icache_pkg::sindex_t                     wr_index_i
   , input  icache_pkg::way_t                        wr_way_i
   , input  icache_pkg::ptag_t                       wr_tag_i
   , input  logic                                    wr_valid_i
   , output icache_pkg::ptag_t [icache_pkg::assoc-1:0] tag_o
   , output icache_pkg::way_mask_t                   valid_o
   );

  icache_pkg::ptag_t [icache_pkg::assoc-1:0]   tag_mem [icache_pkg::sets];
  icache_pkg::way_mask_t [icache_pkg::sets-1:0] valid_r;

  // Tags are plain storage
  always_ff @(posedge clk_i)
  begin
    if (wr_v_i)
      tag_mem[wr_index_i][wr_way_i] <= wr_tag_i;
    if (rd_v_i)
      tag_o <= tag_mem[rd_index_i];
  end

  // Valid bits start clear so every way misses after reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r <= '0;
      valid_o <= '0;
    end
    else
    begin
      if (wr_v_i)
        valid_r[wr_index_i][wr_way_i] <= wr_valid_i;
      if (rd_v_i)
        valid_o <= valid_r[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// ==== icache_data_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_data_array
  (input  logic                                        clk_i
   , input  logic                                      rd_v_i
   , input  icache_pkg::sindex_t                       rd_index_i
   , input  logic [icache_pkg::bank_offset_width-1:0]  rd_bank_offset_i
   , input  logic                                      wr_v_i
   , input  icache_pkg::sindex_t                       wr_index_i
   , input  icache_pkg::way_t                          wr_way_i
   , input  icache_pkg::block_t                        wr_block_i
   , output icache_pkg::bank_t [icache_pkg::assoc-1:0] bank_o
   );

  ////////////////////
  // Bank interleave
  ////////////////////
  // Word k of way w sits in bank (k + w) mod 2 at entry {index, k}.
  // A read of offset k therefore addresses the same entry in both banks,
  // and each bank returns that word for a different way.

  for (genvar b = 0; b < icache_pkg::assoc; b++)
  begin : g_bank
    localparam logic [icache_pkg::bank_offset_width-1:0] bank_id = b;

    icache_pkg::bank_t mem_r [icache_pkg::sets << icache_pkg::bank_offset_width];

    logic [icache_pkg::bank_offset_width-1:0] wr_offset;
    icache_pkg::bank_t                         wr_data;

    // Undo the rotation to find which word of the block lands here
    assign wr_offset = bank_id - wr_way_i;
    assign wr_data   = wr_block_i[wr_offset*icache_pkg::bank_width +: icache_pkg::bank_width];

    always_ff @(posedge clk_i)
    begin
      if (wr_v_i)
        mem_r[{wr_index_i, wr_offset}] <= wr_data;
      if (rd_v_i)
        bank_o[b] <= mem_r[{rd_index_i, rd_bank_offset_i}];
    end
  end

endmodule

`default_nettype wire

// ==== icache_lru_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_lru_array
  (input  logic                  clk_i
   , input  logic                reset_i
   , input  logic                hit_consumed_i
   , input  icache_pkg::sindex_t hit_index_i
   , input  icache_pkg::way_t    hit_way_i
   , input  icache_pkg::sindex_t tv_index_i
   , input  icache_pkg::way_mask_t valid_i
   , output icache_pkg::way_t    repl_way_o
   );

  // Each entry names the way to evict next
  icache_pkg::way_t [icache_pkg::sets-1:0] lru_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      lru_r <= '0;
    else if (hit_consumed_i)
      lru_r[hit_index_i] <= ~hit_way_i;
  end

  ////////////////////
  // Victim choice
  ////////////////////
  // Walk down so the lowest invalid way is the one left standing
  always_comb
  begin
    repl_way_o = lru_r[tv_index_i];
    for (int w = icache_pkg::assoc-1; w >= 0; w--)
    begin
      if (!valid_i[w])
        repl_way_o = icache_pkg::way_t'(w);
    end
  end

endmodule

`default_nettype wire

// ==== icache_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_pipeline
  (input  logic                                        clk_i
   , input  logic                                      reset_i
   , input  icache_pkg::vaddr_t                        vaddr_i
   , input  logic                                      v_i
   , input  icache_pkg::ptag_t                         ptag_i
   , input  logic                                      ptag_v_i
   , input  logic                                      data_yumi_i
   , input  logic                                      ready_i
   , input  logic                                      cache_req_ready_i
   , input  logic                                      is_recover_i
   , output logic                                      yumi_o
   , output logic                                      tl_we_o
   , output logic                                      tv_we_o
   , output logic                                      arr_rd_v_o
   , output icache_pkg::sindex_t                       arr_index_o
   , output logic [icache_pkg::bank_offset_width-1:0]  arr_bank_offset_o
   , input  icache_pkg::ptag_t [icache_pkg::assoc-1:0] tag_i
   , input  icache_pkg::way_mask_t                     valid_i
   , input  icache_pkg::bank_t [icache_pkg::assoc-1:0] bank_i
   , output icache_pkg::instr_t                        data_o
   , output logic                                      data_v_o
   , output icache_pkg::paddr_t                        tv_paddr_o
   , output logic                                      tv_miss_o
   , output icache_pkg::way_mask_t                     tv_valid_o
   , output logic                                      hit_consumed_o
   , output icache_pkg::way_t                          hit_way_o
   );

  localparam int bank_lsb = icache_pkg::block_offset_width - icache_pkg::bank_offset_width;

  logic                                      v_tl_r;
  icache_pkg::vaddr_t                        vaddr_tl_r;
  logic                                      v_tv_r;
  icache_pkg::paddr_t                        paddr_tv_r;
  icache_pkg::way_mask_t                     hit_tv_r;
  icache_pkg::way_mask_t                     valid_tv_r;
  icache_pkg::bank_t [icache_pkg::assoc-1:0] bank_tv_r;

  logic                                     tl_adv;
  icache_pkg::ptag_t                        cmp_tag;
  icache_pkg::way_mask_t                    hit_tl;
  logic [icache_pkg::bank_offset_width-1:0] bank_sel;
  icache_pkg::bank_t                        bank_pick;

  ////////////////////
  // Stage handshakes
  ////////////////////
  assign tv_we_o = ~v_tv_r | (data_v_o & data_yumi_i);
  assign tl_adv  = v_tl_r & tv_we_o & ptag_v_i;
  assign yumi_o  = v_i & ready_i & cache_req_ready_i & (~v_tl_r | tl_adv);
  assign tl_we_o = yumi_o;

  // Array port. While a miss waits, keep reading the TV set so the result is
  // fresh when recover comes; recover itself restores the set held in TL
  assign arr_rd_v_o = tl_we_o | ~ready_i;

  always_comb
  begin
    if (ready_i)
    begin
      arr_index_o       = vaddr_i[icache_pkg::block_offset_width +: icache_pkg::sindex_width];
      arr_bank_offset_o = vaddr_i[bank_lsb +: icache_pkg::bank_offset_width];
    end
    else if (is_recover_i)
    begin
      arr_index_o       = vaddr_tl_r[icache_pkg::block_offset_width +: icache_pkg::sindex_width];
      arr_bank_offset_o = vaddr_tl_r[bank_lsb +: icache_pkg::bank_offset_width];
    end
    else
    begin
      arr_index_o       = paddr_tv_r[icache_pkg::block_offset_width +: icache_pkg::sindex_width];
      arr_bank_offset_o = paddr_tv_r[bank_lsb +: icache_pkg::bank_offset_width];
    end
  end

  ////////////////////
  // TL stage
  ////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_tl_r <= 1'b0;
    else if (tl_we_o)
      v_tl_r <= 1'b1;
    else if (tl_adv)
      v_tl_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_we_o)
      vaddr_tl_r <= vaddr_i;
  end

  // Recover compares the re-read against the tag already held in TV
  assign cmp_tag = is_recover_i
    ? paddr_tv_r[icache_pkg::page_offset_width +: icache_pkg::ptag_width]
    : ptag_i;

  always_comb
  begin
    for (int w = 0; w < icache_pkg::assoc; w++)
      hit_tl[w] = valid_i[w] & (tag_i[w] == cmp_tag);
  end

  ////////////////////
  // TV stage
  ////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_tv_r <= 1'b0;
    else if (tv_we_o)
      v_tv_r <= v_tl_r & ptag_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_adv)
    begin
      paddr_tv_r <= {ptag_i, vaddr_tl_r[icache_pkg::page_offset_width-1:0]};
      valid_tv_r <= valid_i;
    end
    if (tl_adv | is_recover_i)
    begin
      hit_tv_r  <= hit_tl;
      bank_tv_r <= bank_i;
    end
  end

  // Lowest hitting way
  always_comb
  begin
    hit_way_o = '0;
    for (int w = icache_pkg::assoc-1; w >= 0; w--)
    begin
      if (hit_tv_r[w])
        hit_way_o = icache_pkg::way_t'(w);
    end
  end

  // The word lives in bank (offset + way)
  assign bank_sel  = hit_way_o + paddr_tv_r[bank_lsb +: icache_pkg::bank_offset_width];
  assign bank_pick = bank_tv_r[bank_sel];
  assign data_o    = bank_pick[paddr_tv_r[bank_lsb-1]*icache_pkg::instr_width
                               +: icache_pkg::instr_width];

  assign data_v_o       = v_tv_r & (|hit_tv_r);
  assign tv_miss_o      = v_tv_r & ~(|hit_tv_r);
  assign hit_consumed_o = data_v_o & data_yumi_i;
  assign tv_paddr_o     = paddr_tv_r;
  assign tv_valid_o     = valid_tv_r;

endmodule

`default_nettype wire

// ==== icache_miss_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_miss_fsm
  (input  logic                 clk_i
   , input  logic               reset_i
   , input  logic               tv_miss_i
   , input  icache_pkg::paddr_t tv_paddr_i
   , input  icache_pkg::way_t   repl_way_i
   , input  logic               cache_req_ready_i
   , input  logic               cache_req_complete_i
   , output logic               ready_o
   , output logic               is_recover_o
   , output logic               cache_req_v_o
   , output icache_pkg::paddr_t cache_req_addr_o
   , output logic               cache_req_metadata_v_o
   , output icache_pkg::way_t   cache_req_repl_way_o
   );

  icache_pkg::icache_state_e state_r;
  icache_pkg::icache_state_e state_n;
  icache_pkg::way_t          repl_way_r;

  assign ready_o      = (state_r == icache_pkg::e_ready);
  assign is_recover_o = (state_r == icache_pkg::e_recover);

  // Only the ready state may issue, so each miss sends one request
  assign cache_req_v_o    = ready_o & tv_miss_i & cache_req_ready_i;
  assign cache_req_addr_o = {tv_paddr_i[icache_pkg::paddr_width-1:icache_pkg::block_offset_width],
                             {icache_pkg::block_offset_width{1'b0}}};

  always_comb
  begin
    case (state_r)
      icache_pkg::e_ready:
        state_n = cache_req_v_o ? icache_pkg::e_miss : icache_pkg::e_ready;
      icache_pkg::e_miss:
        state_n = cache_req_complete_i ? icache_pkg::e_recover : icache_pkg::e_miss;
      icache_pkg::e_recover:
        state_n = icache_pkg::e_ready;
      default:
        state_n = icache_pkg::e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r                <= icache_pkg::e_ready;
      cache_req_metadata_v_o <= 1'b0;
    end
    else
    begin
      state_r                <= state_n;
      cache_req_metadata_v_o <= cache_req_v_o;
    end
  end

  // Victim is fixed when the request leaves
  always_ff @(posedge clk_i)
  begin
    if (cache_req_v_o)
      repl_way_r <= repl_way_i;
  end

  assign cache_req_repl_way_o = repl_way_r;

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_top
  (input  logic                  clk_i
   , input  logic                reset_i
   , input  icache_pkg::vaddr_t  vaddr_i
   , input  logic                v_i
   , output logic                yumi_o
   , input  icache_pkg::ptag_t   ptag_i
   , input  logic                ptag_v_i
   , output logic                tl_we_o
   , output logic                tv_we_o
   , output icache_pkg::instr_t  data_o
   , output logic                data_v_o
   , input  logic                data_yumi_i
   , output logic                cache_req_v_o
   , output icache_pkg::paddr_t  cache_req_addr_o
   , input  logic                cache_req_ready_i
   , output logic                cache_req_metadata_v_o
   , output icache_pkg::way_t    cache_req_repl_way_o
   , input  logic                cache_req_complete_i
   , input  logic                tag_pkt_v_i
   , input  icache_pkg::sindex_t tag_pkt_index_i
   , input  icache_pkg::way_t    tag_pkt_way_i
   , input  icache_pkg::ptag_t   tag_pkt_tag_i
   , input  logic                tag_pkt_valid_i
   , output logic                tag_pkt_yumi_o
   , input  logic                data_pkt_v_i
   , input  icache_pkg::sindex_t data_pkt_index_i
   , input  icache_pkg::way_t    data_pkt_way_i
   , input  icache_pkg::block_t  data_pkt_data_i
   , output logic                data_pkt_yumi_o
   );

  logic                                      ready;
  logic                                      is_recover;
  logic                                      arr_rd_v;
  icache_pkg::sindex_t                       arr_index;
  logic [icache_pkg::bank_offset_width-1:0]  arr_bank_offset;
  icache_pkg::ptag_t [icache_pkg::assoc-1:0] tag_rd;
  icache_pkg::way_mask_t                     valid_rd;
  icache_pkg::bank_t [icache_pkg::assoc-1:0] bank_rd;
  icache_pkg::paddr_t                        tv_paddr;
  icache_pkg::sindex_t                       tv_index;
  logic                                      tv_miss;
  icache_pkg::way_mask_t                     tv_valid;
  logic                                      hit_consumed;
  icache_pkg::way_t                          hit_way;
  icache_pkg::way_t                          repl_way;

  // Engine writes wait while the pipeline owns the arrays
  assign tag_pkt_yumi_o  = tag_pkt_v_i & ~(tl_we_o | is_recover);
  assign data_pkt_yumi_o = data_pkt_v_i & ~(tl_we_o | is_recover);

  assign tv_index = tv_paddr[icache_pkg::block_offset_width +: icache_pkg::sindex_width];

  icache_pipeline pipeline_i
    (.clk_i, .reset_i, .vaddr_i, .v_i, .ptag_i, .ptag_v_i, .data_yumi_i
     ,.ready_i(ready), .cache_req_ready_i, .is_recover_i(is_recover)
     ,.yumi_o, .tl_we_o, .tv_we_o
     ,.arr_rd_v_o(arr_rd_v), .arr_index_o(arr_index), .arr_bank_offset_o(arr_bank_offset)
     ,.tag_i(tag_rd), .valid_i(valid_rd), .bank_i(bank_rd)
     ,.data_o, .data_v_o
     ,.tv_paddr_o(tv_paddr), .tv_miss_o(tv_miss), .tv_valid_o(tv_valid)
     ,.hit_consumed_o(hit_consumed), .hit_way_o(hit_way)
     );

  icache_tag_array tag_array_i
    (.clk_i, .reset_i, .rd_v_i(arr_rd_v), .rd_index_i(arr_index)
     ,.wr_v_i(tag_pkt_yumi_o), .wr_index_i(tag_pkt_index_i), .wr_way_i(tag_pkt_way_i)
     ,.wr_tag_i(tag_pkt_tag_i), .wr_valid_i(tag_pkt_valid_i)
     ,.tag_o(tag_rd), .valid_o(valid_rd)
     );

  icache_data_array data_array_i
    (.clk_i, .rd_v_i(arr_rd_v), .rd_index_i(arr_index), .rd_bank_offset_i(arr_bank_offset)
     ,.wr_v_i(data_pkt_yumi_o), .wr_index_i(data_pkt_index_i), .wr_way_i(data_pkt_way_i)
     ,.wr_block_i(data_pkt_data_i), .bank_o(bank_rd)
     );

  icache_lru_array lru_array_i
    (.clk_i, .reset_i, .hit_consumed_i(hit_consumed), .hit_index_i(tv_index)
     ,.hit_way_i(hit_way), .tv_index_i(tv_index), .valid_i(tv_valid)
     ,.repl_way_o(repl_way)
     );

  icache_miss_fsm miss_fsm_i
    (.clk_i, .reset_i, .tv_miss_i(tv_miss), .tv_paddr_i(tv_paddr), .repl_way_i(repl_way)
     ,.cache_req_ready_i, .cache_req_complete_i
     ,.ready_o(ready), .is_recover_o(is_recover)
     ,.cache_req_v_o, .cache_req_addr_o, .cache_req_metadata_v_o, .cache_req_repl_way_o
     );

endmodule

`default_nettype wire

// ==== icache_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_checker
  (input  logic               clk_i
   , input  logic             reset_i
   , input  logic             yumi_i
   , input  icache_pkg::instr_t data_i
   , input  logic             data_v_i
   , input  logic             data_yumi_i
   , input  logic             cache_req_v_i
   , input  logic             cache_req_metadata_v_i
   , input  logic             cache_req_complete_i
   );

  int unsigned error_count = 0;
  logic        outstanding_r;

  // A request stays open until the engine reports completion
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      outstanding_r <= 1'b0;
    else if (cache_req_v_i)
      outstanding_r <= 1'b1;
    else if (cache_req_complete_i)
      outstanding_r <= 1'b0;
  end

  ////////////////////
  // Request rules
  ////////////////////
  a_meta_after_req : assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_i |=> cache_req_metadata_v_i)
  else
  begin
    error_count++;
    $error("Metadata valid did not follow the request");
  end

  a_meta_needs_req : assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_metadata_v_i |-> $past(cache_req_v_i))
  else
  begin
    error_count++;
    $error("Metadata valid came without a request one cycle earlier");
  end

  a_no_fetch_in_miss : assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_r |-> !yumi_i)
  else
  begin
    error_count++;
    $error("A fetch was accepted while a request was outstanding");
  end

  ////////////////////
  // Output hold
  ////////////////////
  a_data_held : assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_i && !data_yumi_i |=> data_v_i && $stable(data_i))
  else
  begin
    error_count++;
    $error("Output data changed while it was not consumed");
  end

endmodule

`default_nettype wire

// ==== icache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

  localparam int                   timeout_cycles = 40;
  localparam int                   drive_delay    = 2;
  localparam icache_pkg::ptag_t    ptag_offset    = 20'h00400;
  localparam icache_pkg::instr_t   mem_key        = 32'h5A3C_96E1;
  localparam icache_pkg::sindex_t  test_index     = 6'h23;

  logic                  clk_i;
  logic                  reset_i;
  icache_pkg::vaddr_t    vaddr_i;
  logic                  v_i;
  logic                  yumi_o;
  icache_pkg::ptag_t     ptag_i;
  logic                  ptag_v_i;
  logic                  tl_we_o;
  logic                  tv_we_o;
  icache_pkg::instr_t    data_o;
  logic                  data_v_o;
  logic                  data_yumi_i;
  logic                  cache_req_v_o;
  icache_pkg::paddr_t    cache_req_addr_o;
  logic                  cache_req_ready_i;
  logic                  cache_req_metadata_v_o;
  icache_pkg::way_t      cache_req_repl_way_o;
  logic                  cache_req_complete_i;
  logic                  tag_pkt_v_i;
  icache_pkg::sindex_t   tag_pkt_index_i;
  icache_pkg::way_t      tag_pkt_way_i;
  icache_pkg::ptag_t     tag_pkt_tag_i;
  logic                  tag_pkt_valid_i;
  logic                  tag_pkt_yumi_o;
  logic                  data_pkt_v_i;
  icache_pkg::sindex_t   data_pkt_index_i;
  icache_pkg::way_t      data_pkt_way_i;
  icache_pkg::block_t    data_pkt_data_i;
  logic                  data_pkt_yumi_o;

  icache_pkg::instr_t    exp_q[$];
  icache_pkg::instr_t    got_q[$];
  int                    got_cycle_q[$];
  int                    cycle_count = 0;
  int                    req_count = 0;
  icache_pkg::vaddr_t    accepted_vaddr;

  icache_top icache_top_i (.*);

  bind icache_top icache_checker checker_i
    (.clk_i, .reset_i, .yumi_i(yumi_o), .data_i(data_o), .data_v_i(data_v_o), .data_yumi_i
     ,.cache_req_v_i(cache_req_v_o), .cache_req_metadata_v_i(cache_req_metadata_v_o)
     ,.cache_req_complete_i
     );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i)
    cycle_count <= cycle_count + 1;

  ////////////////////
  // Reference model
  ////////////////////
  function automatic icache_pkg::vaddr_t make_vaddr(input logic [19:0] vtag,
                                                    input icache_pkg::sindex_t idx,
                                                    input logic [1:0] word);
    return {vtag, 2'b00, idx, word, 2'b00};
  endfunction

  function automatic icache_pkg::ptag_t phys_tag(input icache_pkg::vaddr_t va);
    return va[31:12] + ptag_offset;
  endfunction

  function automatic icache_pkg::paddr_t phys_addr(input icache_pkg::vaddr_t va);
    return {phys_tag(va), va[11:0]};
  endfunction

  function automatic icache_pkg::instr_t mem_word(input icache_pkg::paddr_t pa);
    return pa ^ mem_key;
  endfunction

  // Word w of the block sits at bits [32w +: 32]
  function automatic icache_pkg::block_t fill_block(input icache_pkg::paddr_t base);
    icache_pkg::block_t blk;
    for (int w = 0; w < 4; w++)
      blk[w*32 +: 32] = mem_word({base[31:4], 2'(w), 2'b00});
    return blk;
  endfunction

  // TLB stand-in: the tag for the fetch now in TL arrives just after acceptance
  always @(negedge clk_i)
  begin
    if (v_i && yumi_o)
    begin
      accepted_vaddr = vaddr_i;
      @(posedge clk_i);
      #drive_delay;
      ptag_i = phys_tag(accepted_vaddr);
    end
  end

  // Output and request monitors
  always @(negedge clk_i)
  begin
    if (data_v_o && data_yumi_i)
    begin
      got_q.push_back(data_o);
      got_cycle_q.push_back(cycle_count);
    end
    if (cache_req_v_o)
      req_count++;
    if (icache_top_i.checker_i.error_count != 0)
      stop_with_failure("An assertion in the checker failed");
  end

  ////////////////////
  // Checks
  ////////////////////
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_instr(input string test, input icache_pkg::instr_t exp,
                             input icache_pkg::instr_t act);
    if (exp !== act)
      stop_with_failure($sformatf("Fail %s: expected %h, got %h", test, exp, act));
  endtask

  task automatic check_paddr(input string test, input icache_pkg::paddr_t exp,
                             input icache_pkg::paddr_t act);
    if (exp !== act)
      stop_with_failure($sformatf("Fail %s: expected %h, got %h", test, exp, act));
  endtask

  task automatic check_way(input string test, input icache_pkg::way_t exp,
                           input icache_pkg::way_t act);
    if (exp !== act)
      stop_with_failure($sformatf("Fail %s: expected way %0d, got %0d", test, exp, act));
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (exp !== act)
      stop_with_failure($sformatf("Fail %s: expected %b, got %b", test, exp, act));
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    if (exp != act)
      stop_with_failure($sformatf("Fail %s: expected %0d, got %0d", test, exp, act));
  endtask

  ////////////////////
  // Driving tasks
  ////////////////////
  task automatic offer_fetch(input icache_pkg::vaddr_t va);
    v_i = 1'b1;
    vaddr_i = va;
    exp_q.push_back(mem_word(phys_addr(va)));
  endtask

  task automatic wait_accept(input string test);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!yumi_o)
    begin
      n++;
      if (n > timeout_cycles)
        stop_with_failure($sformatf("%s: the fetch was never accepted", test));
      @(negedge clk_i);
    end
    // An accepted fetch writes TL
    check_flag({test, " tl_we_o"}, 1'b1, tl_we_o);
    @(posedge clk_i);
    #drive_delay;
    v_i = 1'b0;
  endtask

  task automatic issue_fetch(input string test, input icache_pkg::vaddr_t va);
    offer_fetch(va);
    wait_accept(test);
  endtask

  task automatic wait_results(input string test, input int count);
    int n;
    n = 0;
    while (got_q.size() < count)
    begin
      n++;
      if (n > timeout_cycles)
        stop_with_failure($sformatf("%s: expected output never arrived", test));
      @(posedge clk_i);
    end
    #drive_delay;
  endtask

  task automatic compare_results(input string test, input int count);
    for (int i = 0; i < count; i++)
    begin
      check_instr(test, exp_q.pop_front(), got_q.pop_front());
      void'(got_cycle_q.pop_front());
    end
  endtask

  // Engine model: check the request, fill the victim way, then report completion
  task automatic serve_miss(input string test, input icache_pkg::paddr_t exp_addr,
                            input icache_pkg::way_t exp_way);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!cache_req_v_o)
    begin
      n++;
      if (n > timeout_cycles)
        stop_with_failure($sformatf("%s: no cache request was raised", test));
      @(negedge clk_i);
    end
    check_paddr(test, exp_addr, cache_req_addr_o);
    @(negedge clk_i);
    check_flag(test, 1'b1, cache_req_metadata_v_o);
    check_way(test, exp_way, cache_req_repl_way_o);
    @(posedge clk_i);
    #drive_delay;
    tag_pkt_v_i      = 1'b1;
    tag_pkt_index_i  = exp_addr[4 +: 6];
    tag_pkt_way_i    = exp_way;
    tag_pkt_tag_i    = exp_addr[31:12];
    tag_pkt_valid_i  = 1'b1;
    data_pkt_v_i     = 1'b1;
    data_pkt_index_i = exp_addr[4 +: 6];
    data_pkt_way_i   = exp_way;
    data_pkt_data_i  = fill_block(exp_addr);
    n = 0;
    @(negedge clk_i);
    while (!(tag_pkt_yumi_o && data_pkt_yumi_o))
    begin
      n++;
      if (n > timeout_cycles)
        stop_with_failure($sformatf("%s: the fill packets were never accepted", test));
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #drive_delay;
    tag_pkt_v_i = 1'b0;
    data_pkt_v_i = 1'b0;
    cache_req_complete_i = 1'b1;
    @(posedge clk_i);
    #drive_delay;
    cache_req_complete_i = 1'b0;
  endtask

  task automatic run_miss(input string test, input icache_pkg::vaddr_t va,
                          input icache_pkg::way_t exp_way);
    icache_pkg::paddr_t pa;
    pa = phys_addr(va);
    issue_fetch(test, va);
    serve_miss(test, {pa[31:4], 4'h0}, exp_way);
    wait_results(test, 1);
    compare_results(test, 1);
  endtask

  task automatic run_hit(input string test, input icache_pkg::vaddr_t va);
    int reqs;
    reqs = req_count;
    issue_fetch(test, va);
    wait_results(test, 1);
    compare_results(test, 1);
    check_count(test, reqs, req_count);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_reset_and_first_miss();
    @(negedge clk_i);
    check_flag("reset yumi_o", 1'b0, yumi_o);
    check_flag("reset data_v_o", 1'b0, data_v_o);
    check_flag("reset cache_req_v_o", 1'b0, cache_req_v_o);
    check_flag("reset metadata_v", 1'b0, cache_req_metadata_v_o);
    check_flag("reset tag_pkt_yumi_o", 1'b0, tag_pkt_yumi_o);
    check_flag("reset data_pkt_yumi_o", 1'b0, data_pkt_yumi_o);
    @(posedge clk_i);
    #drive_delay;
    run_miss("first_miss", make_vaddr(20'h12345, test_index, 2'($urandom % 4)), 1'b0);
  endtask

  task automatic test_block_hits();
    int reqs;
    reqs = req_count;
    for (int w = 0; w < 4; w++)
      issue_fetch("block_hits", make_vaddr(20'h12345, test_index, 2'(w)));
    wait_results("block_hits", 4);
    // Four hits streaming out on consecutive cycles
    check_count("block_hits span", 3, got_cycle_q[3] - got_cycle_q[0]);
    compare_results("block_hits", 4);
    check_count("block_hits requests", reqs, req_count);
  endtask

  task automatic test_replacement();
    run_miss("replacement b", make_vaddr(20'h2A0F1, test_index, 2'($urandom % 4)), 1'b1);
    run_hit("replacement b hit", make_vaddr(20'h2A0F1, test_index, 2'($urandom % 4)));
    run_miss("replacement c", make_vaddr(20'h0BEEF, test_index, 2'($urandom % 4)), 1'b0);
    run_hit("replacement b kept", make_vaddr(20'h2A0F1, test_index, 2'($urandom % 4)));
  endtask

  task automatic test_back_pressure();
    int reqs;
    reqs = req_count;
    data_yumi_i = 1'b0;
    issue_fetch("back_pressure", make_vaddr(20'h2A0F1, test_index, 2'd1));
    issue_fetch("back_pressure", make_vaddr(20'h0BEEF, test_index, 2'd2));
    offer_fetch(make_vaddr(20'h2A0F1, test_index, 2'd3));
    repeat (5)
    begin
      @(negedge clk_i);
      check_flag("back_pressure data_v_o", 1'b1, data_v_o);
      check_instr("back_pressure data_o", exp_q[0], data_o);
      check_flag("back_pressure yumi_o", 1'b0, yumi_o);
      check_flag("back_pressure tv_we_o", 1'b0, tv_we_o);
      check_flag("back_pressure tl_we_o", 1'b0, tl_we_o);
    end
    @(posedge clk_i);
    #drive_delay;
    data_yumi_i = 1'b1;
    wait_accept("back_pressure");
    wait_results("back_pressure", 3);
    compare_results("back_pressure", 3);
    check_count("back_pressure requests", reqs, req_count);
  endtask

  task automatic test_ptag_stall();
    ptag_v_i = 1'b0;
    issue_fetch("ptag_stall", make_vaddr(20'h0BEEF, test_index, 2'($urandom % 4)));
    repeat (4)
    begin
      @(negedge clk_i);
      check_flag("ptag_stall data_v_o", 1'b0, data_v_o);
      // TV is empty while the tag is missing
      check_flag("ptag_stall tv_we_o", 1'b1, tv_we_o);
    end
    @(posedge clk_i);
    #drive_delay;
    ptag_v_i = 1'b1;
    wait_results("ptag_stall", 1);
    compare_results("ptag_stall", 1);
  endtask

  initial
  begin
    void'($urandom(22));
    clk_i = 1'b0;
    reset_i = 1'b1;
    vaddr_i = '0;
    v_i = 1'b0;
    ptag_i = '0;
    ptag_v_i = 1'b1;
    data_yumi_i = 1'b1;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    tag_pkt_v_i = 1'b0;
    tag_pkt_index_i = '0;
    tag_pkt_way_i = '0;
    tag_pkt_tag_i = '0;
    tag_pkt_valid_i = 1'b0;
    data_pkt_v_i = 1'b0;
    data_pkt_index_i = '0;
    data_pkt_way_i = '0;
    data_pkt_data_i = '0;
    repeat (4) @(posedge clk_i);
    #drive_delay;
    reset_i = 1'b0;

    test_reset_and_first_miss();
    test_block_hits();
    test_replacement();
    test_back_pressure();
    test_ptag_stall();

    repeat (3) @(posedge clk_i);
    if (icache_top_i.checker_i.error_count == 0)
    begin
      $display("All tests passed");
      $finish;
    end
    else
      stop_with_failure("An assertion in the checker failed");
  end

endmodule

`default_nettype wire

// ==== files.f ====
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru_array.sv
icache_pipeline.sv
icache_miss_fsm.sv
icache_top.sv
icache_checker.sv
icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_tag_array.sv
  - icache_data_array.sv
  - icache_lru_array.sv
  - icache_pipeline.sv
  - icache_miss_fsm.sv
  - icache_top.sv
  - target: test
    files:
      - icache_checker.sv
      - icache_tb.sv
